/* cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen = 32;

    // RV32I major opcodes
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b  // Second operand straight through, for LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne
    } branch_e;

    // Memory map
    localparam logic [xlen-1:0] led_addr = 32'h0000_0100;
    localparam int ram_words = 64;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One instruction word, several decodings
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        instr_u          instr;
    } if_id_t;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       alu_src_imm;
        branch_e    branch;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic [4:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        logic [xlen-1:0] imm;
        ctrl_t           ctrl;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] result;
        logic [xlen-1:0] store_data;
        ctrl_t           ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic            reg_write;
        logic [4:0]      rd;
        logic [xlen-1:0] value;
    } wb_t;

endpackage

/* fetch.sv */
`timescale 1ns/1ns

module fetch import cpu_pkg::*; (
    input  logic            clock,
    input  logic            rst,
    input  logic            enable,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_target,
    output logic [xlen-1:0] rom_address,
    input  logic [xlen-1:0] rom_data,
    output if_id_t          if_id
);

    logic [xlen-1:0] pc;

    assign rom_address = pc;  // ROM answers in the same cycle

    always_ff @(posedge clock) begin
        if (rst) begin
            pc          <= reset_pc;
            if_id.valid <= 1'b0;
        end else if (enable) begin
            if (redirect) begin
                pc          <= redirect_target;
                if_id.valid <= 1'b0;  // Drop the word fetched down the wrong path
            end else begin
                pc          <= pc + 32'd4;
                if_id.valid <= 1'b1;
            end
            if_id.pc    <= pc;
            if_id.instr <= rom_data;
        end
    end

endmodule

/* decode.sv */
`timescale 1ns/1ns

module decode import cpu_pkg::*; (
    input  logic            clock,
    input  logic            rst,
    input  logic            enable,
    input  logic            redirect,
    input  if_id_t          if_id,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    input  logic [xlen-1:0] rs1_value,
    input  logic [xlen-1:0] rs2_value,
    output id_ex_t          id_ex
);

    instr_u          instr;
    logic [xlen-1:0] imm;
    ctrl_t           ctrl;

    assign instr    = if_id.instr;
    assign rs1_addr = instr.r_fmt.rs1;  // Same bit position in every format
    assign rs2_addr = instr.r_fmt.rs2;

    // Sign-extended immediate, chosen by format
    always_comb begin
        unique case (instr.r_fmt.opcode)
            op_itype, op_load: imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            op_store: imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            op_branch: imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                              instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            op_lui: imm = {instr.u_fmt.imm, 12'h000};
            default: imm = '0;
        endcase
    end

    // Control word; anything unsupported stays all zero and acts as a no-op
    always_comb begin
        ctrl    = '0;
        ctrl.rd = instr.r_fmt.rd;
        unique case (instr.r_fmt.opcode)
            op_rtype: begin
                ctrl.reg_write = 1'b1;
                unique case (instr.r_fmt.funct3)
                    3'b000: ctrl.alu_op = instr.r_fmt.funct7[5] ? alu_sub : alu_add;
                    3'b010: ctrl.alu_op = alu_slt;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b110: ctrl.alu_op = alu_or;
                    3'b111: ctrl.alu_op = alu_and;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            op_itype: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = (instr.i_fmt.funct3 == 3'b000);  // ADDI only
            end
            op_load: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = (instr.i_fmt.funct3 == 3'b010);  // Word loads only
                ctrl.reg_write   = (instr.i_fmt.funct3 == 3'b010);
            end
            op_store: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = (instr.s_fmt.funct3 == 3'b010);
            end
            op_branch: begin
                if (instr.b_fmt.funct3 == 3'b000)
                    ctrl.branch = br_eq;
                else if (instr.b_fmt.funct3 == 3'b001)
                    ctrl.branch = br_ne;
            end
            op_lui: begin
                ctrl.alu_op      = alu_pass_b;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else if (enable) begin
            id_ex.valid     <= if_id.valid && !redirect;  // Squash behind a taken branch
            id_ex.pc        <= if_id.pc;
            id_ex.rs1_value <= rs1_value;
            id_ex.rs2_value <= rs2_value;
            id_ex.imm       <= imm;
            id_ex.ctrl      <= ctrl;
        end
    end

endmodule

/* register_bank.sv */
`timescale 1ns/1ns

module register_bank import cpu_pkg::*; (
    input  logic            clock,
    input  logic            rst,
    input  logic            enable,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [xlen-1:0] rs1_value,
    output logic [xlen-1:0] rs2_value,
    input  wb_t             wb
);

    logic [xlen-1:0] regs [1:31];  // x0 has no storage

    // Read with bypass of the write in flight
    always_comb begin
        rs1_value = regs[rs1_addr];
        if (wb.reg_write && wb.rd == rs1_addr)
            rs1_value = wb.value;
        if (rs1_addr == 5'd0)
            rs1_value = '0;
    end

    always_comb begin
        rs2_value = regs[rs2_addr];
        if (wb.reg_write && wb.rd == rs2_addr)
            rs2_value = wb.value;
        if (rs2_addr == 5'd0)
            rs2_value = '0;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (enable && wb.reg_write && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.value;
        end
    end

endmodule

/* execute.sv */
`timescale 1ns/1ns

module execute import cpu_pkg::*; (
    input  logic            clock,
    input  logic            rst,
    input  logic            enable,
    input  id_ex_t          id_ex,
    output logic            redirect,
    output logic [xlen-1:0] redirect_target,
    output ex_mem_t         ex_mem
);

    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] result;
    logic            taken;

    assign operand_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_value;

    always_comb begin
        unique case (id_ex.ctrl.alu_op)
            alu_add:    result = id_ex.rs1_value + operand_b;
            alu_sub:    result = id_ex.rs1_value - operand_b;
            alu_and:    result = id_ex.rs1_value & operand_b;
            alu_or:     result = id_ex.rs1_value | operand_b;
            alu_xor:    result = id_ex.rs1_value ^ operand_b;
            alu_slt:    result = {31'd0, $signed(id_ex.rs1_value) < $signed(operand_b)};
            alu_pass_b: result = operand_b;
            default:    result = '0;
        endcase
    end

    // Branches compare the two registers, never the immediate
    always_comb begin
        unique case (id_ex.ctrl.branch)
            br_eq:   taken = (id_ex.rs1_value == id_ex.rs2_value);
            br_ne:   taken = (id_ex.rs1_value != id_ex.rs2_value);
            default: taken = 1'b0;
        endcase
    end

    assign redirect        = id_ex.valid && taken;
    assign redirect_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clock) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else if (enable) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.result     <= result;
            ex_mem.store_data <= id_ex.rs2_value;
            ex_mem.ctrl       <= id_ex.ctrl;
        end
    end

endmodule

/* memory.sv */
`timescale 1ns/1ns

module memory import cpu_pkg::*; (
    input  logic            clock,
    input  logic            rst,
    input  logic            enable,
    input  ex_mem_t         ex_mem,
    output logic [5:0]      ram_addr,
    output logic [xlen-1:0] ram_wdata,
    output logic            ram_we,
    input  logic [xlen-1:0] ram_rdata,
    output logic [5:0]      led,
    output wb_t             wb
);

    logic is_led;
    logic store;

    assign is_led    = (ex_mem.result == led_addr);
    assign store     = ex_mem.valid && ex_mem.ctrl.mem_write;
    assign ram_addr  = ex_mem.result[7:2];  // Word index
    assign ram_wdata = ex_mem.store_data;
    assign ram_we    = store && !is_led;

    always_ff @(posedge clock) begin
        if (rst) begin
            led          <= '0;
            wb.reg_write <= 1'b0;
        end else if (enable) begin
            if (store && is_led)
                led <= ex_mem.store_data[5:0];
            wb.reg_write <= ex_mem.valid && ex_mem.ctrl.reg_write;
            wb.rd        <= ex_mem.ctrl.rd;
            wb.value     <= ex_mem.ctrl.mem_read ? ram_rdata : ex_mem.result;  // Load or ALU
        end
    end

endmodule

/* ram.sv */
`timescale 1ns/1ns

module ram import cpu_pkg::*; (
    input  logic            clock,
    input  logic            enable,
    input  logic [5:0]      addr,
    input  logic [xlen-1:0] wdata,
    input  logic            we,
    output logic [xlen-1:0] rdata
);

    logic [xlen-1:0] mem [ram_words];

    assign rdata = mem[addr];  // Asynchronous read

    always_ff @(posedge clock) begin
        if (enable && we)
            mem[addr] <= wdata;
    end

endmodule

/* cpu.sv */
`timescale 1ns/1ns

module cpu import cpu_pkg::*; (
    input  logic            clock,
    input  logic            rst,
    input  logic            enable,
    input  logic [xlen-1:0] rom_data,
    output logic [xlen-1:0] rom_address,
    output logic [5:0]      led
);

    logic            redirect;
    logic [xlen-1:0] redirect_target;
    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    wb_t             wb;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic [5:0]      ram_addr;
    logic [xlen-1:0] ram_wdata;
    logic [xlen-1:0] ram_rdata;
    logic            ram_we;

    fetch u_fetch (
        .clock           (clock),
        .rst             (rst),
        .enable          (enable),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .rom_address     (rom_address),
        .rom_data        (rom_data),
        .if_id           (if_id)
    );

    decode u_decode (
        .clock     (clock),
        .rst       (rst),
        .enable    (enable),
        .redirect  (redirect),
        .if_id     (if_id),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .id_ex     (id_ex)
    );

    register_bank u_register_bank (
        .clock     (clock),
        .rst       (rst),
        .enable    (enable),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wb        (wb)
    );

    execute u_execute (
        .clock           (clock),
        .rst             (rst),
        .enable          (enable),
        .id_ex           (id_ex),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .ex_mem          (ex_mem)
    );

    memory u_memory (
        .clock     (clock),
        .rst       (rst),
        .enable    (enable),
        .ex_mem    (ex_mem),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata),
        .led       (led),
        .wb        (wb)
    );

    ram u_ram (
        .clock  (clock),
        .enable (enable),
        .addr   (ram_addr),
        .wdata  (ram_wdata),
        .we     (ram_we),
        .rdata  (ram_rdata)
    );

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;

    localparam int period = 100;
    localparam int rom_depth = 64;
    localparam int test_total = 5;
    localparam int cycles_per_test = 10 + rom_depth + 48;  // Reset, program, loop and stall
    localparam int watchdog_ns = (test_total * cycles_per_test + 20) * period;
    localparam logic [31:0] nop = 32'h0000_0013;  // ADDI x0, x0, 0

    logic        clock;
    logic        rst;
    logic        enable;
    logic [31:0] rom_data;
    logic [31:0] rom_address;
    logic [5:0]  led;

    logic [31:0] rom [rom_depth];
    int          loc;
    integer      seed;
    int          errors;
    int          failed_tests;
    logic        led_chk;
    logic [5:0]  led_exp;
    logic [31:0] arith_store_pc;
    logic [5:0]  arith_led;

    cpu u_cpu (
        .clock       (clock),
        .rst         (rst),
        .enable      (enable),
        .rom_data    (rom_data),
        .rom_address (rom_address),
        .led         (led)
    );

    // Combinational ROM, NOP outside the program
    always_comb begin
        if (rom_address[31:8] == 24'd0)
            rom_data = rom[rom_address[7:2]];
        else
            rom_data = nop;
    end

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not complete within %0d ns", watchdog_ns);
        $display("Verification failed");
        $finish;
    end

    assert property (@(posedge clock) led_chk |-> led == led_exp)
        else begin
            errors++;
            $display("Mismatch led: expected %h, got %h", $sampled(led_exp), $sampled(led));
        end

    // One edge of reset brings the PC and LED back
    assert property (@(posedge clock) rst |=> rom_address == 32'd0 && led == 6'd0)
        else begin
            errors++;
            $display("Mismatch rom_address/led after reset: expected 0/0, got %h/%h",
                     $sampled(rom_address), $sampled(led));
        end

    // Hand assembly
    function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input int imm);
        return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input int imm);
        return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input int imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] br(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input int off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input int upper);
        return {upper[19:0], rd, 7'b0110111};
    endfunction

    function automatic int small_imm();
        return ($random(seed) & 32'h7ff) - 32'h400;  // -1024 to 1023
    endfunction

    task automatic step();
        @(posedge clock);
        #10;
    endtask

    task automatic clear_rom();
        for (int i = 0; i < rom_depth; i++)
            rom[i] = nop;
        loc = 0;
    endtask

    task automatic put(input logic [31:0] word);
        rom[loc] = word;
        loc++;
    endtask

    task automatic pad(input int n);
        repeat (n) put(nop);
    endtask

    task automatic restart();
        rst = 1'b1;
        repeat (10) step();
        rst = 1'b0;
    endtask

    // Arms the concurrent led check for the next edge
    task automatic expect_led(input logic [5:0] value);
        led_exp = value;
        led_chk = 1'b1;
        step();
        led_chk = 1'b0;
    endtask

    task automatic wait_for_address(input logic [31:0] addr);
        int n;
        n = 0;
        while (rom_address != addr && n < 2 * rom_depth) begin
            step();
            n++;
        end
        if (rom_address != addr) begin
            errors++;
            $display("Program never fetched address %h", addr);
        end
    endtask

    // Store word captured one edge after its address, LED written three edges later
    task automatic run_to_store(input logic [31:0] addr, input logic [5:0] value);
        wait_for_address(addr);
        repeat (3) step();
        expect_led(6'h00);
        expect_led(value);
    endtask

    // Enable low for a while, fetch address and LED must not move
    task automatic hold_disabled(input int cycles);
        logic [31:0] held_addr;
        logic [5:0]  held_led;
        enable = 1'b0;
        held_addr = rom_address;
        held_led = led;
        repeat (cycles) begin
            step();
            assert (rom_address == held_addr)
                else begin
                    errors++;
                    $display("Mismatch rom_address: expected %h, got %h", held_addr, rom_address);
                end
            assert (led == held_led)
                else begin
                    errors++;
                    $display("Mismatch led: expected %h, got %h", held_led, led);
                end
        end
        enable = 1'b1;
    endtask

    task automatic report(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("%-12s ok", name);
        end else begin
            $display("%-12s FAILED", name);
            failed_tests++;
        end
    endtask

    task automatic reset_state();
        int start;
        start = errors;
        clear_rom();
        restart();
        assert (rom_address == 32'd0)
            else begin
                errors++;
                $display("Mismatch rom_address: expected %h, got %h", 32'd0, rom_address);
            end
        assert (led == 6'd0)
            else begin
                errors++;
                $display("Mismatch led: expected %h, got %h", 6'd0, led);
            end
        repeat (3) step();
        report("reset", start);
    endtask

    task automatic arithmetic();
        int start;
        int a;
        int b;
        int upper;
        int lui_val;
        int r10;
        int r11;
        int r12;
        int r13;
        int r16;
        start = errors;
        a = small_imm();
        b = small_imm();
        upper = $random(seed) & 32'hfffff;
        lui_val = upper << 12;
        clear_rom();
        put(addi(20, 0, 32'h100));
        put(addi(1, 0, a));
        put(addi(2, 0, b));
        put(lui(9, upper));
        pad(3);
        put(r_op(7'h00, 3'b000, 3, 1, 2));  // ADD
        put(r_op(7'h20, 3'b000, 4, 1, 2));  // SUB
        put(r_op(7'h00, 3'b111, 5, 1, 2));  // AND
        put(r_op(7'h00, 3'b110, 6, 1, 2));  // OR
        put(r_op(7'h00, 3'b100, 7, 1, 2));  // XOR
        put(r_op(7'h00, 3'b010, 8, 1, 2));  // SLT
        put(r_op(7'h00, 3'b010, 13, 9, 1));
        pad(3);
        put(r_op(7'h20, 3'b000, 10, 3, 4));
        put(r_op(7'h00, 3'b100, 11, 5, 6));
        put(r_op(7'h00, 3'b000, 12, 7, 8));
        pad(3);
        put(r_op(7'h00, 3'b000, 14, 10, 11));
        put(r_op(7'h00, 3'b110, 15, 12, 13));
        pad(3);
        put(r_op(7'h00, 3'b100, 16, 14, 15));
        pad(3);
        arith_store_pc = loc * 4;
        put(sw(16, 20, 0));
        r10 = (a + b) - (a - b);
        r11 = (a & b) ^ (a | b);
        r12 = (a ^ b) + ((a < b) ? 1 : 0);
        r13 = (lui_val < a) ? 1 : 0;
        r16 = (r10 + r11) ^ (r12 | r13);
        arith_led = r16[5:0];
        restart();
        run_to_store(arith_store_pc, arith_led);
        report("arithmetic", start);
    endtask

    // Same program as arithmetic, stalled early and again while the store sits in EX/MEM
    task automatic stall_with_enable();
        int start;
        start = errors;
        restart();
        repeat (8) step();
        hold_disabled(5);
        wait_for_address(arith_store_pc);
        repeat (3) step();
        hold_disabled(5);  // LED write pending
        expect_led(6'h00);
        expect_led(arith_led);
        report("enable", start);
    endtask

    task automatic load_store();
        int start;
        int a;
        int b;
        int c;
        int sum;
        logic [31:0] store_pc;
        start = errors;
        a = small_imm();
        b = small_imm();
        c = small_imm();
        clear_rom();
        put(addi(20, 0, 32'h100));
        put(addi(1, 0, a));
        put(addi(2, 0, b));
        put(addi(3, 0, c));
        pad(3);
        put(sw(1, 0, 16));
        put(sw(2, 0, 36));
        put(sw(3, 0, 60));
        put(lw(4, 0, 16));
        put(lw(5, 0, 36));
        put(lw(6, 0, 60));
        pad(3);
        put(r_op(7'h00, 3'b000, 7, 4, 5));
        pad(3);
        put(r_op(7'h20, 3'b000, 8, 7, 6));
        pad(3);
        store_pc = loc * 4;
        put(sw(8, 20, 0));
        sum = a + b - c;
        restart();
        run_to_store(store_pc, sum[5:0]);
        report("memory", start);
    endtask

    task automatic branch_and_loop();
        int start;
        int count;
        int total;
        logic [31:0] loop_pc;
        logic [31:0] bne_pc;
        logic [31:0] store_pc;
        start = errors;
        count = 2 + ($random(seed) & 3);
        clear_rom();
        put(addi(20, 0, 32'h100));
        put(addi(1, 0, count));
        pad(3);
        put(br(3'b000, 0, 0, 12));  // Taken BEQ skips x6 and x7
        put(addi(6, 0, 1));
        put(addi(7, 0, 2));
        put(br(3'b001, 0, 0, 12));  // Untaken BNE
        put(addi(4, 0, 4));
        put(addi(5, 0, 8));
        loop_pc = loc * 4;
        put(addi(2, 2, 3));
        put(addi(1, 1, -1));
        pad(3);
        bne_pc = loc * 4;
        put(br(3'b001, 1, 0, loop_pc - bne_pc));
        pad(3);
        put(r_op(7'h00, 3'b000, 8, 2, 4));
        put(r_op(7'h00, 3'b000, 9, 5, 6));
        pad(3);
        put(r_op(7'h00, 3'b000, 10, 8, 9));
        pad(3);
        put(r_op(7'h00, 3'b000, 11, 10, 7));
        pad(3);
        store_pc = loc * 4;
        put(sw(11, 20, 0));
        total = count * 3 + 4 + 8;
        restart();
        wait_for_address(bne_pc);
        repeat (3) step();
        assert (rom_address == loop_pc)
            else begin
                errors++;
                $display("Mismatch rom_address: expected %h, got %h", loop_pc, rom_address);
            end
        run_to_store(store_pc, total[5:0]);
        report("branch", start);
    endtask

    initial begin
        rst = 1'b1;
        enable = 1'b1;
        led_chk = 1'b0;
        led_exp = '0;
        seed = 32'hccf2;
        errors = 0;
        failed_tests = 0;
        clear_rom();
        reset_state();
        arithmetic();
        stall_with_enable();
        load_store();
        branch_and_loop();
        $display("%0d tests, %0d failed, %0d errors", test_total, failed_tests, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* verilog.f */
cpu_pkg.sv
fetch.sv
decode.sv
register_bank.sv
execute.sv
memory.sv
ram.sv
cpu.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - fetch.sv
  - decode.sv
  - register_bank.sv
  - execute.sv
  - memory.sv
  - ram.sv
  - cpu.sv
  - target: test
    files:
      - tb_cpu.sv
